//--- hw/fir_num_pkg.sv
package fir_num_pkg;

    localparam int num_taps = 4;
    localparam int sample_width = 16;
    localparam int coef_width = 16;
    localparam int product_width = sample_width + coef_width;
    localparam int acc_width = product_width + $clog2(num_taps);  // Two guard bits for four taps.

    // Approximate multiplier shape. Rows below approx_rows are pruned under keep column.
    localparam int approx_rows = 6;
    localparam int approx_keep_column = 14;

    typedef logic signed [sample_width-1:0] sample_t;

    typedef logic signed [coef_width-1:0] coef_t;

    typedef logic signed [product_width-1:0] product_t;

    typedef logic signed [acc_width-1:0] acc_t;

    // Index 0 holds the newest sample.
    typedef sample_t [num_taps-1:0] sample_vec_t;

    typedef coef_t [num_taps-1:0] coef_vec_t;

    typedef product_t [num_taps-1:0] product_vec_t;

endpackage

//--- hw/fir_ctrl_pkg.sv
package fir_ctrl_pkg;

    localparam int tap_addr_width = $clog2(fir_num_pkg::num_taps);

    // One mode for the whole filter.
    typedef enum logic {
        mode_exact  = 1'b0,
        mode_approx = 1'b1
    } mul_mode_t;

    // Single coefficient write, taken on the edge where en is high.
    typedef struct packed {
        logic                      en;
        logic [tap_addr_width-1:0] addr;
        fir_num_pkg::coef_t        value;
    } coef_write_t;

endpackage

//--- hw/approx_mul16.sv
`timescale 1ns/1ps

module approx_mul16 (
    input  fir_num_pkg::sample_t  x,
    input  fir_num_pkg::coef_t    y,
    output fir_num_pkg::product_t z
);

    logic [15:0] pp [0:15];                                     // Baugh-Wooley rows, one per x bit.
    logic [15:0] kept [0:fir_num_pkg::approx_rows-1];
    logic        pair_bit;
    logic [31:0] sum;

    // Rows 0 to 14 invert the sign column of y.
    for (genvar i = 0; i < 15; i++) begin : g_row
        assign pp[i] = {~(x[i] & y[15]), y[14:0] & {15{x[i]}}};
    end

    // Row 15 carries the sign of x, so its magnitude bits are inverted instead.
    assign pp[15] = {x[15] & y[15], ~(y[14:0] & {15{x[15]}})};

    // Low rows keep only the columns at or above the keep column.
    for (genvar i = 0; i < fir_num_pkg::approx_rows; i++) begin : g_keep
        assign kept[i] = pp[i] & (16'hffff << (fir_num_pkg::approx_keep_column - i));
    end

    // Two pruned bits of column 13 fold into one carry, which never overshoots their sum.
    assign pair_bit = pp[0][13] & pp[1][12];

    // Every pruned bit only lowers the sum, so the error stays below 6 * 2^14.
    always_comb begin
        sum = 32'h8001_0000;                                    // Correction ones at 16 and 31.
        for (int i = 0; i < fir_num_pkg::approx_rows; i++) begin
            sum = sum + (32'(kept[i]) << i);
        end
        for (int i = fir_num_pkg::approx_rows; i < 16; i++) begin
            sum = sum + (32'(pp[i]) << i);
        end
        sum = sum + (32'(pair_bit) << fir_num_pkg::approx_keep_column);
    end

    assign z = fir_num_pkg::product_t'(sum);

endmodule

//--- hw/coef_bank.sv
`timescale 1ns/1ps

module coef_bank (
    input  logic                      clk,
    input  logic                      reset,
    input  fir_ctrl_pkg::coef_write_t coef_write,
    output fir_num_pkg::coef_vec_t    coefs
);

    always_ff @(posedge clk) begin
        if (reset) begin
            coefs <= '0;
        end else if (coef_write.en) begin
            coefs[coef_write.addr] <= coef_write.value;                // Only the addressed tap moves.
        end
    end

    a_addr_known: assert property (
        @(posedge clk) disable iff (reset)
        coef_write.en |-> !$isunknown(coef_write.addr)
    ) else $error("coef_bank: write with unknown address");

endmodule

//--- hw/sample_delay_line.sv
`timescale 1ns/1ps

module sample_delay_line (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     sample_valid,
    input  fir_num_pkg::sample_t     sample,
    output fir_num_pkg::sample_vec_t taps,
    output logic                     taps_valid
);

    always_ff @(posedge clk) begin
        if (reset) begin
            taps       <= '0;
            taps_valid <= 1'b0;
        end else begin
            taps_valid <= sample_valid;
            if (sample_valid) begin
                taps <= {taps[fir_num_pkg::num_taps-2:0], sample};    // Oldest sample drops out.
            end
        end
    end

    // Idle cycles must leave the history alone.
    a_hold_when_idle: assert property (
        @(posedge clk) disable iff (reset)
        !sample_valid |=> $stable(taps)
    ) else $error("sample_delay_line: taps moved without a valid sample");

endmodule

//--- hw/tap_multiplier.sv
`timescale 1ns/1ps

module tap_multiplier (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    in_valid,
    input  fir_ctrl_pkg::mul_mode_t mul_mode,
    input  fir_num_pkg::sample_t    sample,
    input  fir_num_pkg::coef_t      coef,
    output fir_num_pkg::product_t   product,
    output logic                    out_valid
);

    fir_num_pkg::product_t exact_product;
    fir_num_pkg::product_t approx_product;

    assign exact_product = sample * coef;                           // Both operands are signed.

    approx_mul16 u_approx_mul (
        .x (sample),
        .y (coef),
        .z (approx_product)
    );

    // The mode is sampled here, at the multiply stage.
    always_ff @(posedge clk) begin
        if (reset) begin
            product   <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                product <= (mul_mode == fir_ctrl_pkg::mode_approx) ? approx_product
                                                                    : exact_product;
            end
        end
    end

    a_exact_product: assert property (
        @(posedge clk) disable iff (reset)
        in_valid && mul_mode == fir_ctrl_pkg::mode_exact
            |=> product == fir_num_pkg::product_t'($past(sample)) * $past(coef)
    ) else $error("tap_multiplier: exact product does not match operands");

endmodule

//--- hw/tap_adder_tree.sv
`timescale 1ns/1ps

module tap_adder_tree (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  fir_num_pkg::product_vec_t products,
    output fir_num_pkg::acc_t         sum,
    output logic                      sum_valid
);

    fir_num_pkg::acc_t sum_lo;
    fir_num_pkg::acc_t sum_hi;
    fir_num_pkg::acc_t sum_next;

    // First level, products sign-extended to the full sum width.
    assign sum_lo = fir_num_pkg::acc_t'(products[0]) + fir_num_pkg::acc_t'(products[1]);
    assign sum_hi = fir_num_pkg::acc_t'(products[2]) + fir_num_pkg::acc_t'(products[3]);

    assign sum_next = sum_lo + sum_hi;                               // Guard bits absorb the carry.

    always_ff @(posedge clk) begin
        if (reset) begin
            sum       <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= in_valid;
            if (in_valid) begin
                sum <= sum_next;
            end
        end
    end

    // Upstream stages are cleared too, so nothing can leak out right after reset.
    a_quiet_after_reset: assert property (
        @(posedge clk)
        reset |-> ##1 !sum_valid ##1 !sum_valid
    ) else $error("tap_adder_tree: sum_valid high just after reset");

endmodule

//--- hw/approx_fir_top.sv
`timescale 1ns/1ps

module approx_fir_top (
    input  logic                      clk,
    input  logic                      reset,
    input  fir_ctrl_pkg::coef_write_t coef_write,
    input  fir_ctrl_pkg::mul_mode_t   mul_mode,
    input  logic                      sample_valid,
    input  fir_num_pkg::sample_t      sample,
    output logic                      result_valid,
    output fir_num_pkg::acc_t         result
);

    fir_num_pkg::coef_vec_t           coef_vec;
    fir_num_pkg::sample_vec_t         taps;
    logic                             taps_valid;
    fir_num_pkg::product_vec_t        product_vec;
    logic                             prod_valid;

    coef_bank u_coef_bank (
        .clk        (clk),
        .reset      (reset),
        .coef_write (coef_write),
        .coefs      (coef_vec)
    );

    sample_delay_line u_delay_line (
        .clk          (clk),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample       (sample),
        .taps         (taps),
        .taps_valid   (taps_valid)
    );

    for (genvar i = 0; i < fir_num_pkg::num_taps; i++) begin : g_tap
        if (i == 0) begin : g_lead
            tap_multiplier u_tap_mul (
                .clk       (clk),
                .reset     (reset),
                .in_valid  (taps_valid),
                .mul_mode  (mul_mode),
                .sample    (taps[i]),
                .coef      (coef_vec[i]),
                .product   (product_vec[i]),
                .out_valid (prod_valid)                            // Tap 0 speaks for all taps.
            );
        end else begin : g_follow
            tap_multiplier u_tap_mul (
                .clk       (clk),
                .reset     (reset),
                .in_valid  (taps_valid),
                .mul_mode  (mul_mode),
                .sample    (taps[i]),
                .coef      (coef_vec[i]),
                .product   (product_vec[i]),
                .out_valid ()
            );
        end
    end

    tap_adder_tree u_adder_tree (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (prod_valid),
        .products  (product_vec),
        .sum       (result),
        .sum_valid (result_valid)
    );

endmodule

//--- tests/tb_approx_fir.sv
`timescale 1ns/1ps

module tb_approx_fir;

    localparam int clk_period = 40;
    localparam int reset_cycles = 8;
    localparam int random_count = 200;
    localparam int num_samples = 4 + 2 * random_count + 8 + 6;    // Impulse, two random runs, rewrite, gaps.
    localparam int watchdog_cycles = 2 * num_samples + 100;       // A sample costs at most two cycles.
    localparam longint approx_bound = longint'(4) << 22;          // Four products, each off by under 2^22.

    logic                      clk;
    logic                      reset;
    fir_ctrl_pkg::coef_write_t coef_write;
    fir_ctrl_pkg::mul_mode_t   mul_mode;
    logic                      sample_valid;
    fir_num_pkg::sample_t      sample;
    logic                      result_valid;
    fir_num_pkg::acc_t         result;

    fir_num_pkg::sample_t ref_history [0:fir_num_pkg::num_taps-1];  // Index 0 is the newest sample.
    fir_num_pkg::coef_t   ref_coefs [0:fir_num_pkg::num_taps-1];
    longint               exp_sum [0:num_samples-1];
    longint               exp_bound [0:num_samples-1];
    int                   push_count;
    int                   pop_count;

    fir_num_pkg::sample_t random_samples [0:random_count-1];
    bit                   random_gaps [0:random_count-1];

    int          value_errors;
    int          timing_errors;
    int          other_errors;

    approx_fir_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .coef_write   (coef_write),
        .mul_mode     (mul_mode),
        .sample_valid (sample_valid),
        .sample       (sample),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Sum over the taps of coefficient times the sample of that age.
    function automatic longint exact_fir_sum();
        longint acc;
        acc = 0;
        for (int k = 0; k < fir_num_pkg::num_taps; k++) begin
            acc += longint'(ref_history[k]) * longint'(ref_coefs[k]);
        end
        return acc;
    endfunction

    function automatic bit result_in_bound(longint got, int idx);
        longint diff;
        if (idx >= push_count) begin
            return 1'b0;                                          // A result with no sample behind it.
        end
        diff = got - exp_sum[idx];
        if (diff < 0) begin
            diff = -diff;
        end
        if (exp_bound[idx] == 0) begin
            return diff == 0;
        end
        return diff < exp_bound[idx];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic idle_cycles(input int n);
        sample_valid = 1'b0;
        repeat (n) next_cycle();
    endtask

    task automatic write_coef(input logic [fir_ctrl_pkg::tap_addr_width-1:0] addr,
                              input fir_num_pkg::coef_t value);
        sample_valid = 1'b0;
        coef_write = '{en: 1'b1, addr: addr, value: value};
        ref_coefs[addr] = value;
        next_cycle();
        coef_write = '0;
    endtask

    task automatic send_sample(input fir_num_pkg::sample_t value);
        sample_valid = 1'b1;
        sample = value;
        for (int k = fir_num_pkg::num_taps - 1; k > 0; k--) begin
            ref_history[k] = ref_history[k-1];
        end
        ref_history[0] = value;
        exp_sum[push_count] = exact_fir_sum();
        exp_bound[push_count] = (mul_mode == fir_ctrl_pkg::mode_approx) ? approx_bound : 64'sd0;
        push_count++;
        next_cycle();
        sample_valid = 1'b0;
    endtask

    task automatic run_random_block();
        for (int i = 0; i < random_count; i++) begin
            send_sample(random_samples[i]);
            if (random_gaps[i]) begin
                idle_cycles(1);
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            pop_count <= 0;
        end else if (result_valid) begin
            pop_count <= pop_count + 1;
        end
    end

    a_result_value: assert property (
        @(posedge clk) disable iff (reset)
        result_valid |-> result_in_bound(longint'(result), pop_count)
    ) else begin
        value_errors++;
        $display("MISMATCH at %0t: result %0d for sample %0d, expected %0d within %0d",
                 $time, $sampled(result), $sampled(pop_count),
                 exp_sum[$sampled(pop_count)], exp_bound[$sampled(pop_count)]);
    end

    a_result_latency: assert property (
        @(posedge clk) disable iff (reset)
        sample_valid |-> ##3 result_valid
    ) else begin
        timing_errors++;
        $display("At time %0t a sample got no result three cycles later", $time);
    end

    a_no_stray_result: assert property (
        @(posedge clk) disable iff (reset)
        result_valid |-> $past(sample_valid, 3)
    ) else begin
        timing_errors++;
        $display("At time %0t a result appeared without a sample three cycles before", $time);
    end

    a_quiet_in_reset: assert property (
        @(posedge clk)
        reset && $past(reset) |-> !result_valid
    ) else begin
        timing_errors++;
        $display("At time %0t result_valid was high during reset", $time);
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog expired, the tests did not finish within %0d cycles", watchdog_cycles);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        reset = 1'b1;
        coef_write = '0;
        mul_mode = fir_ctrl_pkg::mode_exact;
        sample_valid = 1'b0;
        sample = '0;
        push_count = 0;
        value_errors = 0;
        timing_errors = 0;
        other_errors = 0;
        for (int k = 0; k < fir_num_pkg::num_taps; k++) begin
            ref_history[k] = '0;
            ref_coefs[k] = '0;
        end
        void'($urandom(32'ha14a_e1f0));
        for (int i = 0; i < random_count; i++) begin
            random_samples[i] = fir_num_pkg::sample_t'($urandom);
            random_gaps[i] = ($urandom % 4) == 0;                 // Mostly back-to-back samples.
        end

        repeat (reset_cycles) @(posedge clk);
        #2;
        reset = 1'b0;
        next_cycle();

        // Impulse response in exact mode.
        write_coef(2'd0, 16'sd3);
        write_coef(2'd1, -16'sd5);
        write_coef(2'd2, 16'sd7);
        write_coef(2'd3, 16'sd11);
        send_sample(16'sd1);
        repeat (3) send_sample(16'sd0);
        idle_cycles(4);

        for (int k = 0; k < fir_num_pkg::num_taps; k++) begin
            write_coef(2'(k), fir_num_pkg::coef_t'($urandom));
        end
        run_random_block();
        idle_cycles(4);

        // Same stimulus with approximate products.
        mul_mode = fir_ctrl_pkg::mode_approx;
        run_random_block();
        idle_cycles(4);
        mul_mode = fir_ctrl_pkg::mode_exact;

        // Samples in flight keep the old coefficient.
        for (int i = 0; i < 4; i++) begin
            send_sample(fir_num_pkg::sample_t'($urandom));
        end
        write_coef(2'd2, fir_num_pkg::coef_t'($urandom));
        for (int i = 0; i < 4; i++) begin
            send_sample(fir_num_pkg::sample_t'($urandom));
        end
        idle_cycles(4);

        for (int i = 0; i < 6; i++) begin
            send_sample(fir_num_pkg::sample_t'($urandom));
            idle_cycles(1 + i % 3);
        end
        idle_cycles(6);

        if (pop_count != push_count) begin
            other_errors++;
            $display("Missing results: %0d samples sent but %0d results seen",
                     push_count, pop_count);
        end
        $display("Errors: %0d value, %0d timing, %0d other",
                 value_errors, timing_errors, other_errors);
        if (value_errors + timing_errors + other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- tb.f
hw/fir_num_pkg.sv
hw/fir_ctrl_pkg.sv
hw/approx_mul16.sv
hw/coef_bank.sv
hw/sample_delay_line.sv
hw/tap_multiplier.sv
hw/tap_adder_tree.sv
hw/approx_fir_top.sv
tests/tb_approx_fir.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_approx_fir --Mdir obj_dir -f tb.f
	./obj_dir/Vtb_approx_fir > $(LOG) 2>&1; cat $(LOG)
	grep -qx "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
